//--- sources.f
+incdir+include
hdl/core_pkg.sv
hdl/inst_buffer.sv
hdl/dispatch_rename.sv
hdl/reorder_buffer.sv
hdl/reservation_station.sv
hdl/alu_pipe.sv
hdl/phys_regfile.sv
hdl/core_top.sv
tests/core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module core_tb \
    -f sources.f -Mdir obj_dir -o core_sim

status=0
./obj_dir/core_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -q "^TEST PASSED$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1

//--- include/core_ref.svh
`ifndef CORE_REF_SVH
`define CORE_REF_SVH

//////////////////////////////
// architectural model
//////////////////////////////

// in-order result of one instruction, regs updated in place
function automatic core_pkg::commit_t ref_commit(
    input core_pkg::inst_t inst,
    ref   core_pkg::data_t regs [core_pkg::arch_regs]
);
    core_pkg::commit_t exp;
    core_pkg::data_t   a;
    core_pkg::data_t   b;
    core_pkg::data_t   res;

    a = regs[inst.src1];
    b = regs[inst.src2];
    case (inst.op)
        core_pkg::op_li:  res = inst.imm;   // sources ignored
        core_pkg::op_add: res = a + b;
        core_pkg::op_sub: res = a - b;
        core_pkg::op_and: res = a & b;
        core_pkg::op_xor: res = a ^ b;
        default:          res = '0;
    endcase
    regs[inst.dest] = res;

    exp.valid = 1'b1;
    exp.dest  = inst.dest;
    exp.data  = res;
    return exp;
endfunction

`endif

//--- tests/core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module core_tb import core_pkg::*; ();

    localparam int space_limit = 200;   // cycles waiting for ib_space
    localparam int drain_limit = 1000;  // cycles waiting for the last commit

    logic    clock;
    logic    reset;
    inst_t   in_inst;
    logic    in_valid;
    logic    ib_space;
    commit_t commit;

    data_t   model_regs [arch_regs];    // architectural state in program order
    commit_t exp_q [$];
    logic    saw_full;

    `include "core_ref.svh"

    core_top u_core_top (
        .clock    (clock),
        .reset    (reset),
        .in_inst  (in_inst),
        .in_valid (in_valid),
        .ib_space (ib_space),
        .commit   (commit)
    );

    always #2 clock = ~clock;

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_commit(input commit_t got, input commit_t exp);
        if (got !== exp) begin
            $display(
                "MISMATCH time=%0t signal=commit got=dest %0d data %h expected=dest %0d data %h",
                $time, got.dest, got.data, exp.dest, exp.data);
            fail_run();
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
            fail_run();
        end
    endtask

    // commit monitor sampled mid-cycle
    always @(negedge clock) begin
        if (!reset && commit.valid) begin
            if (exp_q.size() == 0) begin
                $display("commit at %0t arrived with no instruction outstanding", $time);
                fail_run();
            end else begin
                check_commit(commit, exp_q.pop_front());
            end
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // starts and ends 1 ns after a rising edge
    task automatic send(input inst_t inst);
        int waited;
        waited = 0;
        while (!ib_space) begin
            saw_full = 1'b1;
            @(posedge clock);
            #1;
            waited++;
            if (waited > space_limit) begin
                $display("timeout: ib_space stayed low for %0d cycles", waited);
                fail_run();
            end
        end
        in_inst  = inst;
        in_valid = 1'b1;
        exp_q.push_back(ref_commit(inst, model_regs));
        @(posedge clock);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic idle_maybe();
        if ($urandom % 4 == 0) begin
            @(posedge clock);
            #1;
        end
    endtask

    function automatic inst_t random_inst();
        inst_t inst;
        inst.op   = op_e'(3'($urandom % 5));
        inst.dest = arch_reg_t'($urandom % arch_regs);
        inst.src1 = arch_reg_t'($urandom % arch_regs);
        inst.src2 = arch_reg_t'($urandom % arch_regs);
        inst.imm  = data_t'($urandom);
        return inst;
    endfunction

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clock);
            #1;
            waited++;
            if (waited > drain_limit) begin
                $display("timeout: %0d instructions never committed", exp_q.size());
                fail_run();
            end
        end
    endtask

    initial begin
        inst_t     inst;
        arch_reg_t prev_dest;

        clock        = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_inst      = '0;
        saw_full     = 1'b0;
        prev_dest    = '0;
        for (int i = 0; i < arch_regs; i++)
            model_regs[i] = '0;
        void'($urandom(32'hf7be_fca6));

        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        check_level("commit.valid", commit.valid, 1'b0);
        check_level("ib_space", ib_space, 1'b1);

        // load every register
        for (int r = 0; r < arch_regs; r++) begin
            inst      = random_inst();
            inst.op   = op_li;
            inst.dest = arch_reg_t'(r);
            send(inst);
        end

        // each op reads the previous result
        for (int n = 0; n < 40; n++) begin
            inst = random_inst();
            if (inst.op == op_li)
                inst.op = op_add;
            inst.src1 = prev_dest;
            if (n % 3 == 0)
                inst.src2 = prev_dest;
            prev_dest = inst.dest;
            send(inst);
            idle_maybe();
        end

        //////////////////////////////
        // back to back
        //////////////////////////////

        saw_full = 1'b0;
        repeat (300) send(random_inst());
        check_level("ib_space_dropped", saw_full, 1'b1);

        // only two destinations so tags must recycle
        for (int n = 0; n < 48; n++) begin
            inst      = random_inst();
            inst.dest = arch_reg_t'(1 + $urandom % 2);
            inst.src1 = arch_reg_t'(1 + $urandom % 2);
            inst.src2 = arch_reg_t'(1 + $urandom % 2);
            send(inst);
            idle_maybe();
        end

        wait_for_drain();
        repeat (20) @(posedge clock);   // catch stray commits
        #1;

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top import core_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  inst_t   in_inst,
    input  logic    in_valid,
    output logic    ib_space,
    output commit_t commit
);

    inst_t     head_inst;
    logic      head_valid;
    logic      dispatch;
    renamed_t  renamed;
    logic      rob_full;
    logic      rs_full;
    rob_idx_t  rob_tail;
    phys_reg_t free_tag;
    renamed_t  issue;
    logic      issue_valid;
    phys_reg_t rd_tag_1;
    phys_reg_t rd_tag_2;
    data_t     rd_data_1;
    data_t     rd_data_2;
    cdb_t      cdb;           // single source, the ALU

    //////////////////////////////
    // front end
    //////////////////////////////

    inst_buffer u_inst_buffer (
        .clock      (clock),
        .reset      (reset),
        .in_inst    (in_inst),
        .in_valid   (in_valid),
        .dispatch   (dispatch),
        .head_inst  (head_inst),
        .head_valid (head_valid),
        .ib_space   (ib_space)
    );

    dispatch_rename u_dispatch_rename (
        .clock      (clock),
        .reset      (reset),
        .head_inst  (head_inst),
        .head_valid (head_valid),
        .rob_full   (rob_full),
        .rs_full    (rs_full),
        .rob_tail   (rob_tail),
        .cdb        (cdb),
        .commit     (commit),
        .free_tag   (free_tag),
        .dispatch   (dispatch),
        .renamed    (renamed)
    );

    //////////////////////////////
    // back end
    //////////////////////////////

    reservation_station u_reservation_station (
        .clock       (clock),
        .reset       (reset),
        .dispatch    (dispatch),
        .renamed     (renamed),
        .cdb         (cdb),
        .rs_full     (rs_full),
        .issue       (issue),
        .issue_valid (issue_valid)
    );

    alu_pipe u_alu_pipe (
        .clock       (clock),
        .reset       (reset),
        .issue       (issue),
        .issue_valid (issue_valid),
        .rd_tag_1    (rd_tag_1),
        .rd_tag_2    (rd_tag_2),
        .rd_data_1   (rd_data_1),
        .rd_data_2   (rd_data_2),
        .cdb         (cdb)
    );

    phys_regfile u_phys_regfile (
        .clock     (clock),
        .reset     (reset),
        .rd_tag_1  (rd_tag_1),
        .rd_tag_2  (rd_tag_2),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2),
        .cdb       (cdb)
    );

    reorder_buffer u_reorder_buffer (
        .clock    (clock),
        .reset    (reset),
        .dispatch (dispatch),
        .renamed  (renamed),
        .cdb      (cdb),
        .rob_tail (rob_tail),
        .rob_full (rob_full),
        .commit   (commit),
        .free_tag (free_tag)
    );

endmodule

`default_nettype wire

//--- hdl/phys_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module phys_regfile import core_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  phys_reg_t rd_tag_1,
    input  phys_reg_t rd_tag_2,
    output data_t     rd_data_1,
    output data_t     rd_data_2,
    input  cdb_t      cdb
);

    data_t regs_q [phys_regs];

    // no bypass, consumers read a cycle after the broadcast
    assign rd_data_1 = regs_q[rd_tag_1];
    assign rd_data_2 = regs_q[rd_tag_2];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < phys_regs; i++)
                regs_q[i] <= '0;
        end else if (cdb.valid) begin
            regs_q[cdb.t] <= cdb.data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/alu_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module alu_pipe import core_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  renamed_t  issue,
    input  logic      issue_valid,
    output phys_reg_t rd_tag_1,
    output phys_reg_t rd_tag_2,
    input  data_t     rd_data_1,
    input  data_t     rd_data_2,
    output cdb_t      cdb
);

    data_t result;

    assign rd_tag_1 = issue.t1;
    assign rd_tag_2 = issue.t2;

    always_comb begin
        case (issue.op)
            op_li:   result = issue.imm;
            op_add:  result = rd_data_1 + rd_data_2;
            op_sub:  result = rd_data_1 - rd_data_2;
            op_and:  result = rd_data_1 & rd_data_2;
            op_xor:  result = rd_data_1 ^ rd_data_2;
            default: result = '0;
        endcase
    end

    // one stage, straight onto the bus
    always_ff @(posedge clock) begin
        if (reset)
            cdb.valid <= 1'b0;
        else
            cdb.valid <= issue_valid;
        cdb.t       <= issue.t;
        cdb.rob_idx <= issue.rob_idx;
        cdb.data    <= result;
    end

endmodule

`default_nettype wire

//--- hdl/reservation_station.sv
`timescale 1ns/10ps
`default_nettype none

module reservation_station import core_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     dispatch,
    input  renamed_t renamed,
    input  cdb_t     cdb,
    output logic     rs_full,
    output renamed_t issue,
    output logic     issue_valid
);

    typedef logic [$clog2(rs_depth)-1:0] rs_idx_t;
    typedef logic [$clog2(rs_depth):0]   rs_cnt_t;

    renamed_t            entry_q [rs_depth];
    rs_idx_t             age_q   [rs_depth];   // number of older entries
    logic [rs_depth-1:0] valid_q;
    logic [rs_depth-1:0] ready;
    rs_idx_t             sel_idx;
    rs_idx_t             free_idx;
    rs_cnt_t             occupancy;

    //////////////////////////////
    // select
    //////////////////////////////

    always_comb begin
        issue_valid = 1'b0;
        sel_idx     = '0;
        free_idx    = '0;
        occupancy   = '0;
        for (int i = 0; i < rs_depth; i++) begin
            ready[i] = valid_q[i] && entry_q[i].t1_ready && entry_q[i].t2_ready;
            if (valid_q[i])
                occupancy = occupancy + 1'b1;
        end
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!valid_q[i])
                free_idx = rs_idx_t'(i);   // lowest open slot
        end
        // oldest ready wins
        for (int i = 0; i < rs_depth; i++) begin
            if (ready[i] && (!issue_valid || age_q[i] < age_q[sel_idx])) begin
                issue_valid = 1'b1;
                sel_idx     = rs_idx_t'(i);
            end
        end
    end

    assign issue   = entry_q[sel_idx];
    assign rs_full = &valid_q;

    //////////////////////////////
    // entry state
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            for (int i = 0; i < rs_depth; i++)
                age_q[i] <= '0;
        end else begin
            for (int i = 0; i < rs_depth; i++) begin
                // younger ones move up when an older entry leaves
                if (issue_valid && valid_q[i] && age_q[i] > age_q[sel_idx])
                    age_q[i] <= age_q[i] - 1'b1;
            end
            if (issue_valid)
                valid_q[sel_idx] <= 1'b0;
            if (dispatch) begin
                valid_q[free_idx] <= 1'b1;
                age_q[free_idx]   <= rs_idx_t'(occupancy - rs_cnt_t'(issue_valid));
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_depth; i++) begin
            if (cdb.valid && entry_q[i].t1 == cdb.t)
                entry_q[i].t1_ready <= 1'b1;   // wakeup
            if (cdb.valid && entry_q[i].t2 == cdb.t)
                entry_q[i].t2_ready <= 1'b1;
        end
        if (dispatch)
            entry_q[free_idx] <= renamed;
    end

endmodule

`default_nettype wire

//--- hdl/reorder_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer import core_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      dispatch,
    input  renamed_t  renamed,
    input  cdb_t      cdb,
    output rob_idx_t  rob_tail,
    output logic      rob_full,
    output commit_t   commit,
    output phys_reg_t free_tag
);

    rob_idx_t             head_q;
    rob_idx_t             tail_q;
    logic [rob_depth-1:0] valid_q;
    logic [rob_depth-1:0] done_q;
    arch_reg_t            dest_q  [rob_depth];
    phys_reg_t            t_old_q [rob_depth];
    data_t                data_q  [rob_depth];
    logic                 retire;

    assign rob_tail = tail_q;
    assign rob_full = valid_q[tail_q];   // tail caught up with head
    assign retire   = valid_q[head_q] && done_q[head_q];

    //////////////////////////////
    // control and commit
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q       <= '0;
            tail_q       <= '0;
            valid_q      <= '0;
            done_q       <= '0;
            commit.valid <= 1'b0;
        end else begin
            if (cdb.valid)
                done_q[cdb.rob_idx] <= 1'b1;
            if (retire) begin
                valid_q[head_q] <= 1'b0;
                done_q[head_q]  <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            if (dispatch) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end
            commit.valid <= retire;
        end
        commit.dest <= dest_q[head_q];
        commit.data <= data_q[head_q];
        free_tag    <= t_old_q[head_q];
    end

    always_ff @(posedge clock) begin
        if (dispatch) begin
            dest_q[tail_q]  <= renamed.dest;
            t_old_q[tail_q] <= renamed.t_old;
        end
        if (cdb.valid)
            data_q[cdb.rob_idx] <= cdb.data;
    end

    // each dispatched entry completes exactly once
    a_cdb_slot: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> valid_q[cdb.rob_idx] && !done_q[cdb.rob_idx])
        else $error("reorder_buffer: CDB hit an empty or done slot");

endmodule

`default_nettype wire

//--- hdl/dispatch_rename.sv
`timescale 1ns/10ps
`default_nettype none

module dispatch_rename import core_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  inst_t     head_inst,
    input  logic      head_valid,
    input  logic      rob_full,
    input  logic      rs_full,
    input  rob_idx_t  rob_tail,
    input  cdb_t      cdb,
    input  commit_t   commit,
    input  phys_reg_t free_tag,
    output logic      dispatch,
    output renamed_t  renamed
);

    typedef logic [$clog2(phys_regs - arch_regs)-1:0] fl_ptr_t;
    typedef logic [$clog2(phys_regs - arch_regs):0]   fl_cnt_t;

    phys_reg_t            map_q [arch_regs];
    phys_reg_t            fl_q  [phys_regs - arch_regs];
    fl_ptr_t              fl_head_q;
    fl_ptr_t              fl_tail_q;
    fl_cnt_t              fl_count_q;
    logic [phys_regs-1:0] busy_q;

    assign dispatch = head_valid && !rob_full && !rs_full && (fl_count_q != '0);

    //////////////////////////////
    // rename
    //////////////////////////////

    always_comb begin
        renamed.op      = head_inst.op;
        renamed.imm     = head_inst.imm;
        renamed.t       = fl_q[fl_head_q];
        renamed.t_old   = map_q[head_inst.dest];
        renamed.t1      = map_q[head_inst.src1];
        renamed.t2      = map_q[head_inst.src2];
        renamed.dest    = head_inst.dest;
        renamed.rob_idx = rob_tail;
        // li has no sources to wait on
        // a tag on the CDB this cycle counts as ready
        renamed.t1_ready = (head_inst.op == op_li) || !busy_q[renamed.t1] ||
                           (cdb.valid && cdb.t == renamed.t1);
        renamed.t2_ready = (head_inst.op == op_li) || !busy_q[renamed.t2] ||
                           (cdb.valid && cdb.t == renamed.t2);
    end

    //////////////////////////////
    // tables
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < arch_regs; i++)
                map_q[i] <= phys_reg_t'(i);   // identity map
            for (int i = 0; i < phys_regs - arch_regs; i++)
                fl_q[i] <= phys_reg_t'(arch_regs + i);
            fl_head_q  <= '0;
            fl_tail_q  <= '0;
            fl_count_q <= fl_cnt_t'(phys_regs - arch_regs);
            busy_q     <= '0;
        end else begin
            if (cdb.valid)
                busy_q[cdb.t] <= 1'b0;
            if (dispatch) begin
                map_q[head_inst.dest] <= renamed.t;
                busy_q[renamed.t]     <= 1'b1;
                fl_head_q             <= fl_head_q + 1'b1;
            end
            // retiring t_old goes back on the list
            if (commit.valid) begin
                fl_q[fl_tail_q] <= free_tag;
                fl_tail_q       <= fl_tail_q + 1'b1;
            end
            fl_count_q <= fl_count_q + fl_cnt_t'(commit.valid) - fl_cnt_t'(dispatch);
        end
    end

    // more tags returned than handed out
    a_fl_no_overflow: assert property (@(posedge clock) disable iff (reset)
        commit.valid |-> dispatch || fl_count_q != fl_cnt_t'(phys_regs - arch_regs))
        else $error("dispatch_rename: free list overflow on commit");

endmodule

`default_nettype wire

//--- hdl/inst_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module inst_buffer import core_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  inst_t in_inst,
    input  logic  in_valid,
    input  logic  dispatch,
    output inst_t head_inst,
    output logic  head_valid,
    output logic  ib_space
);

    typedef logic [$clog2(ib_depth)-1:0] ib_ptr_t;
    typedef logic [$clog2(ib_depth):0]   ib_cnt_t;

    inst_t   entries_q [ib_depth];
    ib_ptr_t head_q;
    ib_ptr_t tail_q;
    ib_cnt_t count_q;
    logic    push;

    assign push       = in_valid && ib_space;
    assign head_inst  = entries_q[head_q];
    assign head_valid = (count_q != '0);
    assign ib_space   = (count_q < ib_cnt_t'(ib_depth));

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push)
                tail_q <= tail_q + 1'b1;
            if (dispatch)
                head_q <= head_q + 1'b1;   // pop in the dispatch cycle
            count_q <= count_q + ib_cnt_t'(push) - ib_cnt_t'(dispatch);
        end
    end

    always_ff @(posedge clock) begin
        if (push)
            entries_q[tail_q] <= in_inst;
    end

    // source must respect ib_space
    a_no_push_full: assert property (@(posedge clock) disable iff (reset)
        in_valid |-> ib_space)
        else $error("inst_buffer: push while full");

    // dispatch only pops a visible head
    a_no_pop_empty: assert property (@(posedge clock) disable iff (reset)
        dispatch |-> head_valid)
        else $error("inst_buffer: pop while empty");

endmodule

`default_nettype wire

//--- hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    //////////////////////////////
    // sizes
    //////////////////////////////

    localparam int arch_regs  = 8;
    localparam int phys_regs  = 16;
    localparam int rob_depth  = 8;
    localparam int rs_depth   = 4;
    localparam int ib_depth   = 4;
    localparam int data_width = 16;

    typedef logic [$clog2(arch_regs)-1:0] arch_reg_t;
    typedef logic [$clog2(phys_regs)-1:0] phys_reg_t;
    typedef logic [$clog2(rob_depth)-1:0] rob_idx_t;
    typedef logic [data_width-1:0]        data_t;

    typedef enum logic [2:0] {
        op_li,
        op_add,
        op_sub,
        op_and,
        op_xor
    } op_e;

    //////////////////////////////
    // pipeline packets
    //////////////////////////////

    // as it arrives from the source
    typedef struct packed {
        op_e       op;
        arch_reg_t dest;
        arch_reg_t src1;
        arch_reg_t src2;
        data_t     imm;
    } inst_t;

    typedef struct packed {
        op_e       op;
        data_t     imm;
        phys_reg_t t;        // new mapping of dest
        phys_reg_t t_old;    // freed when this one retires
        phys_reg_t t1;
        logic      t1_ready;
        phys_reg_t t2;
        logic      t2_ready;
        arch_reg_t dest;
        rob_idx_t  rob_idx;
    } renamed_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t t;
        rob_idx_t  rob_idx;
        data_t     data;
    } cdb_t;

    typedef struct packed {
        logic      valid;
        arch_reg_t dest;
        data_t     data;
    } commit_t;

endpackage

`default_nettype wire
